// ==== rtl/board_test_params.svh ====
/* Register map and frame constants for the board test core.
   Addresses are 7 bits wide; the config bit positions assume an 8-bit config byte. */

`ifndef BOARD_TEST_PARAMS_SVH
`define BOARD_TEST_PARAMS_SVH

// Register addresses seen by the microcontroller
`define REG_ID      7'd0
`define REG_CONFIG  7'd1
`define REG_LED     7'd2
`define REG_SCRATCH 7'd3

// Constant returned at REG_ID
`define BOARD_ID 8'h4d

// Bits per chip-select window
// read flag, 7 address bits, 8 data bits
`define SPI_FRAME_BITS 16

// Bit positions inside the config byte
`define CFG_TMDS_EN_BIT  0
`define CFG_VCXO_OFF_BIT 1

`endif

// ==== rtl/board_test_pkg.sv ====
/* Shared types for the board test core.
   Field order puts the first member in the most significant bits. */

`default_nettype none

package board_test_pkg;

	// Register access from the SPI target
	// write is a single-cycle strobe
	// addr stays valid until the next frame reaches its address bits
	typedef struct packed {
		logic       write;
		logic [6:0] addr;
		logic [7:0] wdata;
	} reg_req_t;

	// Configuration byte as driven to the board
	// tmds_enable sits in bit 0, vcxo_off in bit 1
	typedef struct packed {
		logic [5:0] spare;
		logic       vcxo_off;
		logic       tmds_enable;
	} ext_config_t;

	// Parallel TMDS symbols, one 10-bit word per channel
	// ch0 carries blue, ch1 green, ch2 red in DVI terms
	// Symbol bit 0 is transmitted first
	typedef struct packed {
		logic [9:0] ch2;
		logic [9:0] ch1;
		logic [9:0] ch0;
	} tmds_symbols_t;

endpackage

`default_nettype wire

// ==== rtl/mmc_spi_slave.sv ====
/* SPI mode 0 target for the microcontroller, sampled with clk.
   SCLK must run at clk/8 or slower; short frames are dropped when CSB rises. */

`default_nettype none

`include "board_test_params.svh"

module mmc_spi_slave (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       sclk,
	input  wire                       csb,
	input  wire                       mosi,
	input  wire  [7:0]                rdata,
	output logic                      miso,
	output board_test_pkg::reg_req_t  req
);

	// Pin synchronizers
	// sclk_sr[2] is the previous synchronized level, for edge detection
	logic [2:0]  sclk_sr;
	logic [1:0]  csb_sr;
	logic [1:0]  mosi_sr;
	logic        sclk_rise;
	logic        sclk_fall;
	logic        csb_s;
	logic        mosi_s;

	// Frame state
	logic [4:0]  bit_cnt;
	logic [6:0]  rx_shift;
	logic [7:0]  rx_byte;
	logic        rd_flag;
	logic        load_pend;
	logic [7:0]  tx_shift;

	// Request fields
	logic        write_q;
	logic [6:0]  addr_q;
	logic [7:0]  wdata_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sclk_sr <= 3'b000;
			// CSB idles high, so come out of reset deselected
			csb_sr  <= 2'b11;
			mosi_sr <= 2'b00;
		end else begin
			sclk_sr <= {sclk_sr[1:0], sclk};
			csb_sr  <= {csb_sr[0], csb};
			mosi_sr <= {mosi_sr[0], mosi};
		end
	end

	assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
	assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
	assign csb_s     = csb_sr[1];
	assign mosi_s    = mosi_sr[1];

	// Byte completed by the current MOSI bit
	assign rx_byte = {rx_shift, mosi_s};

	// Input shifter, MSB first
	always_ff @(posedge clk) begin
		if (!csb_s && sclk_rise)
			rx_shift <= {rx_shift[5:0], mosi_s};
	end

	// Bit counter and request generation
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt   <= 5'd0;
			rd_flag   <= 1'b0;
			addr_q    <= 7'd0;
			load_pend <= 1'b0;
			write_q   <= 1'b0;
		end else begin
			write_q   <= 1'b0;
			load_pend <= 1'b0;
			if (csb_s) begin
				bit_cnt <= 5'd0;
			end else if (sclk_rise && bit_cnt < (`SPI_FRAME_BITS)) begin
				bit_cnt <= bit_cnt + 5'd1;
				// Eighth bit closes the command byte
				if (bit_cnt == (`SPI_FRAME_BITS) / 2 - 1) begin
					rd_flag   <= rx_byte[7];
					addr_q    <= rx_byte[6:0];
					load_pend <= 1'b1;
				end
				// Last bit of a write frame
				if (bit_cnt == (`SPI_FRAME_BITS) - 1 && !rd_flag)
					write_q <= 1'b1;
			end
		end
	end

	// Write data captured with the final bit
	always_ff @(posedge clk) begin
		if (!csb_s && sclk_rise && bit_cnt == (`SPI_FRAME_BITS) - 1)
			wdata_q <= rx_byte;
	end

	// Output shifter
	// addr_q updates with the eighth bit, so rdata is loaded one cycle later
	// Shifting starts on the falling edge after the ninth bit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			tx_shift <= 8'h00;
		else if (csb_s)
			tx_shift <= 8'h00;
		else if (load_pend)
			tx_shift <= rd_flag ? rdata : 8'h00;
		else if (sclk_fall && bit_cnt > (`SPI_FRAME_BITS) / 2)
			tx_shift <= {tx_shift[6:0], 1'b0};
	end

	assign miso = tx_shift[7];

	assign req = '{write: write_q, addr: addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

// ==== rtl/config_regs.sv ====
/* Small register file behind the SPI target.
   Read data is combinational from req.addr; writes to ID or unmapped addresses are dropped. */

`default_nettype none

`include "board_test_params.svh"

module config_regs (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire  board_test_pkg::reg_req_t req,
	output logic [7:0]                   rdata,
	output board_test_pkg::ext_config_t  cfg,
	output logic [7:0]                   led
);

	// Register contents
	logic [7:0] config_q;
	logic [7:0] led_q;
	logic [7:0] scratch_q;

	// Address decode for write strobes
	logic wr_config;
	logic wr_led;
	logic wr_scratch;

	assign wr_config  = req.write && (req.addr == `REG_CONFIG);
	assign wr_led     = req.write && (req.addr == `REG_LED);
	assign wr_scratch = req.write && (req.addr == `REG_SCRATCH);

	// Registers that drive board outputs
	// Cleared so TMDS is off and the VCXO runs after reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			config_q <= 8'h00;
			led_q    <= 8'h00;
		end else begin
			if (wr_config)
				config_q <= req.wdata;
			if (wr_led)
				led_q <= req.wdata;
		end
	end

	// Scratch byte is only read back
	always_ff @(posedge clk) begin
		if (wr_scratch)
			scratch_q <= req.wdata;
	end

	// Read mux
	// ID is a constant; unmapped addresses read zero
	always_comb begin
		case (req.addr)
			`REG_ID:      rdata = `BOARD_ID;
			`REG_CONFIG:  rdata = config_q;
			`REG_LED:     rdata = led_q;
			`REG_SCRATCH: rdata = scratch_q;
			default:      rdata = 8'h00;
		endcase
	end

	// Map config byte onto named fields
	always_comb begin
		cfg.tmds_enable = config_q[`CFG_TMDS_EN_BIT];
		cfg.vcxo_off    = config_q[`CFG_VCXO_OFF_BIT];
		// Remaining bits carried along unused
		cfg.spare       = config_q[7:2];
	end

	assign led = led_q;

endmodule

`default_nettype wire

// ==== rtl/tmds_encoder.sv ====
/* DVI 1.0 TMDS encoder for one channel, one registered symbol per clk.
   Only control code C=00 is emitted while de is low. */

`default_nettype none

module tmds_encoder (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        de,
	input  wire  [7:0] data,
	output logic [9:0] symbol
);

	// Stage one, transition minimized word
	logic [3:0]        n1_d;
	logic              use_xnor;
	logic [8:0]        q_m;

	// Stage two, DC balance
	logic [3:0]        n1_q;
	logic signed [5:0] bal;
	logic signed [5:0] cnt;
	logic signed [5:0] cnt_next;
	logic [9:0]        sym_next;

	always_comb begin
		n1_d = 4'd0;
		for (int i = 0; i < 8; i++)
			n1_d = n1_d + {3'b000, data[i]};
		use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !data[0]);
		q_m[0] = data[0];
		for (int i = 1; i < 8; i++)
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
		q_m[8] = ~use_xnor;
	end

	always_comb begin
		n1_q = 4'd0;
		for (int i = 0; i < 8; i++)
			n1_q = n1_q + {3'b000, q_m[i]};
		// Ones minus zeros of the 8 data bits
		bal = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;
		if (cnt == 6'sd0 || bal == 6'sd0) begin
			sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
			cnt_next = q_m[8] ? cnt + bal : cnt - bal;
		end else if ((cnt > 6'sd0 && bal > 6'sd0) || (cnt < 6'sd0 && bal < 6'sd0)) begin
			// Invert to pull disparity back toward zero
			sym_next = {1'b1, q_m[8], ~q_m[7:0]};
			cnt_next = cnt + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
		end else begin
			sym_next = {1'b0, q_m[8], q_m[7:0]};
			cnt_next = cnt - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
		end
	end

	// Control period resets disparity, as the DVI spec requires
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			symbol <= 10'b1101010100;
			cnt    <= 6'sd0;
		end else if (!de) begin
			symbol <= 10'b1101010100;
			cnt    <= 6'sd0;
		end else begin
			symbol <= sym_next;
			cnt    <= cnt_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tmds_test.sv ====
/* TMDS ramp pattern on three channels while enable is high.
   Output follows enable with two cycles of latency; the ramp restarts at 0 each time. */

`default_nettype none

module tmds_test (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            enable,
	output board_test_pkg::tmds_symbols_t  tmds
);

	logic       en_q;
	logic [7:0] count;
	logic [9:0] sym0;
	logic [9:0] sym1;
	logic [9:0] sym2;

	// Registered enable doubles as data enable
	// Counter holds 0 on the first active cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en_q  <= 1'b0;
			count <= 8'd0;
		end else begin
			en_q  <= enable;
			count <= en_q ? count + 8'd1 : 8'd0;
		end
	end

	// Blue gets the plain ramp
	tmds_encoder enc0_i (
		.clk(clk), .arst_n(arst_n), .de(en_q),
		.data(count), .symbol(sym0)
	);

	// Green carries its inverse
	tmds_encoder enc1_i (
		.clk(clk), .arst_n(arst_n), .de(en_q),
		.data(~count), .symbol(sym1)
	);

	// Red scrambled with 0x55
	tmds_encoder enc2_i (
		.clk(clk), .arst_n(arst_n), .de(en_q),
		.data(count ^ 8'h55), .symbol(sym2)
	);

	assign tmds = '{ch2: sym2, ch1: sym1, ch0: sym0};

endmodule

`default_nettype wire

// ==== rtl/board_test_top.sv ====
/* Portable core of the board bring-up build, all on one ready clock.
   Serializers, clocking and pin buffers live outside; TMDS leaves as parallel symbols. */

`default_nettype none

module board_test_top (
	input  wire                            clk,
	input  wire                            arst_n,

	// SPI pins from the microcontroller
	input  wire                            sclk,
	input  wire                            csb,
	input  wire                            mosi,
	output logic                           miso,

	// Pmod LEDs and VCXO control
	output logic [7:0]                     led,
	output logic                           vcxo_en,

	// Parallel TMDS symbols
	output board_test_pkg::tmds_symbols_t  tmds
);

	import board_test_pkg::*;

	reg_req_t    req;
	ext_config_t cfg;
	logic [7:0]  rdata;

	// Microcontroller access
	mmc_spi_slave spi_i (
		.clk(clk), .arst_n(arst_n),
		.sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.rdata(rdata), .req(req)
	);

	config_regs regs_i (
		.clk(clk), .arst_n(arst_n),
		.req(req), .rdata(rdata),
		.cfg(cfg), .led(led)
	);

	// Pattern generator, gated by config bit 0
	tmds_test tmds_i (
		.clk(clk), .arst_n(arst_n),
		.enable(cfg.tmds_enable),
		.tmds(tmds)
	);

	// VCXO runs unless software turns it off
	assign vcxo_en = ~cfg.vcxo_off;

endmodule

`default_nettype wire

// ==== verification/board_test_tb.sv ====
/* Runs table-driven SPI register accesses, then checks the TMDS ramp through a decoder model.
   SCLK runs at clk/10; DUT outputs are sampled on the falling clock edge. */

`default_nettype none

`include "board_test_params.svh"

module board_test_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import board_test_pkg::*;

	// One SPI transaction and the state expected after it
	typedef struct packed {
		logic       rd;
		logic [6:0] addr;
		logic [7:0] wdata;
		logic [7:0] exp_rdata;
		logic [7:0] exp_led;
		logic       exp_vcxo;
	} spi_step_t;

	localparam int NUM_STEPS = 18;
	// About 180 cycles per frame, plus the TMDS phase
	localparam int CYCLE_LIMIT = NUM_STEPS * 200 + 2000;
	localparam logic [9:0] CTRL_00 = 10'b1101010100;

	logic          clk;
	logic          arst_n;
	logic          sclk;
	logic          csb;
	logic          mosi;
	logic          miso;
	logic [7:0]    led;
	logic          vcxo_en;
	tmds_symbols_t tmds;

	spi_step_t steps [NUM_STEPS];
	integer    seed = 32'hd6eb4830;
	int        cycle_cnt = 0;
	int        check_count = 0;
	int        err_count = 0;
	int        last_rise_cyc = 0;
	int        last_data_cyc = 0;

	// Monitor state
	logic       mon_active = 1'b0;
	logic       mon_seen = 1'b0;
	int         mon_target = 0;
	int         mon_n = 0;
	logic [7:0] mon_exp = 8'h00;
	logic [9:0] sym [3];
	int         disp [3];
	logic       any_data;
	logic       all_data;

	board_test_top dut_i (
		.clk(clk), .arst_n(arst_n),
		.sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.led(led), .vcxo_en(vcxo_en), .tmds(tmds)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	task automatic check(input bit ok, input string msg);
		check_count++;
		assert (ok) else begin
			err_count++;
			$display("Fail at %0d ns: %s", $time, msg);
		end
	endtask

	function automatic spi_step_t make_step(input logic rd, input logic [6:0] addr,
			input logic [7:0] wdata, input logic [7:0] exp_rdata,
			input logic [7:0] exp_led, input logic exp_vcxo);
		spi_step_t s;
		s.rd        = rd;
		s.addr      = addr;
		s.wdata     = wdata;
		s.exp_rdata = exp_rdata;
		s.exp_led   = exp_led;
		s.exp_vcxo  = exp_vcxo;
		return s;
	endfunction

	// Undo DC balancing, then the XOR or XNOR chain
	function automatic logic [7:0] tmds_decode(input logic [9:0] s);
		logic [7:0] q;
		logic [7:0] d;
		q = s[9] ? ~s[7:0] : s[7:0];
		d[0] = q[0];
		for (int i = 1; i < 8; i++)
			d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		return d;
	endfunction

	task automatic fill_table;
		logic [7:0] rnd [4];
		integer     word;
		for (int i = 0; i < 4; i++) begin
			word = $random(seed);
			rnd[i] = word[7:0];
		end
		// ID stays constant and unknown addresses read zero
		steps[0]  = make_step(1, `REG_ID, 8'h00, `BOARD_ID, 8'h00, 1);
		steps[1]  = make_step(0, `REG_ID, 8'ha5, 8'h00, 8'h00, 1);
		steps[2]  = make_step(1, `REG_ID, 8'h00, `BOARD_ID, 8'h00, 1);
		steps[3]  = make_step(1, 7'h55, 8'h00, 8'h00, 8'h00, 1);
		// Random bytes through scratch and LED
		steps[4]  = make_step(0, `REG_SCRATCH, rnd[0], 8'h00, 8'h00, 1);
		steps[5]  = make_step(1, `REG_SCRATCH, 8'h00, rnd[0], 8'h00, 1);
		steps[6]  = make_step(0, `REG_LED, rnd[1], 8'h00, rnd[1], 1);
		steps[7]  = make_step(1, `REG_LED, 8'h00, rnd[1], rnd[1], 1);
		steps[8]  = make_step(0, `REG_SCRATCH, rnd[2], 8'h00, rnd[1], 1);
		steps[9]  = make_step(1, `REG_SCRATCH, 8'h00, rnd[2], rnd[1], 1);
		steps[10] = make_step(0, `REG_LED, rnd[3], 8'h00, rnd[3], 1);
		steps[11] = make_step(1, `REG_LED, 8'h00, rnd[3], rnd[3], 1);
		// VCXO off, then back on
		steps[12] = make_step(0, `REG_CONFIG, 8'h02, 8'h00, rnd[3], 0);
		steps[13] = make_step(1, `REG_CONFIG, 8'h00, 8'h02, rnd[3], 0);
		steps[14] = make_step(0, `REG_CONFIG, 8'h00, 8'h00, rnd[3], 1);
		steps[15] = make_step(1, `REG_CONFIG, 8'h00, 8'h00, rnd[3], 1);
		steps[16] = make_step(0, 7'h5a, 8'hff, 8'h00, rnd[3], 1);
		steps[17] = make_step(1, 7'h5a, 8'h00, 8'h00, rnd[3], 1);
	endtask

	// Mode 0 frame, MSB first, MISO sampled just before each rising SCLK
	// Returns at a falling clk edge, 10 cycles after CSB rises
	task automatic run_frame(input logic [15:0] frame, output logic [7:0] rd_data);
		rd_data = 8'h00;
		@(posedge clk);
		csb <= 1'b0;
		for (int b = 15; b >= 0; b--) begin
			@(posedge clk);
			sclk <= 1'b0;
			mosi <= frame[b];
			repeat (4) @(posedge clk);
			@(negedge clk);
			if (b < 8)
				rd_data[b] = miso;
			@(posedge clk);
			sclk <= 1'b1;
			last_rise_cyc = cycle_cnt;
			repeat (4) @(posedge clk);
		end
		@(posedge clk);
		sclk <= 1'b0;
		mosi <= 1'b0;
		repeat (5) @(posedge clk);
		csb <= 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
	endtask

	// TMDS monitor tracks disparity on every data symbol
	always @(negedge clk) begin
		if (arst_n) begin
			sym[0] = tmds.ch0;
			sym[1] = tmds.ch1;
			sym[2] = tmds.ch2;
			any_data = 1'b0;
			all_data = 1'b1;
			for (int c = 0; c < 3; c++) begin
				if (sym[c] == CTRL_00) begin
					disp[c] = 0;
					all_data = 1'b0;
				end else begin
					any_data = 1'b1;
					disp[c] = disp[c] + 2 * $countones(sym[c]) - 10;
					check(disp[c] >= -10 && disp[c] <= 10,
						$sformatf("ch%0d running disparity %0d out of range", c, disp[c]));
				end
			end
			if (any_data)
				last_data_cyc = cycle_cnt;
			if (!mon_active) begin
				mon_seen = 1'b0;
				mon_n = 0;
				mon_exp = 8'h00;
			end else if (mon_n < mon_target && (mon_seen || any_data)) begin
				mon_seen = 1'b1;
				check(all_data, "control symbol inside the data run");
				check(tmds_decode(sym[0]) == mon_exp, $sformatf("ch0 decoded %02h, expected %02h",
					tmds_decode(sym[0]), mon_exp));
				check(tmds_decode(sym[1]) == ~mon_exp, $sformatf("ch1 decoded %02h, expected %02h",
					tmds_decode(sym[1]), ~mon_exp));
				check(tmds_decode(sym[2]) == (mon_exp ^ 8'h55), $sformatf(
					"ch2 decoded %02h, expected %02h", tmds_decode(sym[2]), mon_exp ^ 8'h55));
				mon_exp = mon_exp + 8'd1;
				mon_n++;
			end
		end
	end

	initial begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [7:0] rd_byte;
		arst_n = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		fill_table();
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);

		// Reset state
		check(led == 8'h00, $sformatf("led %02h after reset", led));
		check(vcxo_en == 1'b1, "vcxo_en low after reset");
		check(tmds == {3{CTRL_00}}, $sformatf("tmds %h after reset", tmds));

		for (int i = 0; i < NUM_STEPS; i++) begin
			run_frame({steps[i].rd, steps[i].addr, steps[i].wdata}, rd_byte);
			if (steps[i].rd)
				check(rd_byte == steps[i].exp_rdata, $sformatf("step %0d read %02h, expected %02h",
					i, rd_byte, steps[i].exp_rdata));
			check(led == steps[i].exp_led, $sformatf("step %0d led %02h, expected %02h",
				i, led, steps[i].exp_led));
			check(vcxo_en == steps[i].exp_vcxo, $sformatf("step %0d vcxo_en %b, expected %b",
				i, vcxo_en, steps[i].exp_vcxo));
		end

		// Long ramp check with TMDS enabled
		mon_target = 1000;
		mon_active = 1'b1;
		run_frame({1'b0, `REG_CONFIG, 8'h01}, rd_byte);
		wait (mon_n == mon_target);
		mon_active = 1'b0;

		// Disabling brings back control symbols shortly after the last SCLK edge
		run_frame({1'b0, `REG_CONFIG, 8'h00}, rd_byte);
		check(tmds == {3{CTRL_00}}, $sformatf("tmds %h after disable", tmds));
		check(last_data_cyc - last_rise_cyc <= 10, $sformatf(
			"data symbols ran %0d cycles past the disabling write", last_data_cyc - last_rise_cyc));

		// Ramp restarts at zero
		mon_target = 16;
		mon_active = 1'b1;
		run_frame({1'b0, `REG_CONFIG, 8'h01}, rd_byte);
		wait (mon_n == mon_target);
		mon_active = 1'b0;

		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/board_test_pkg.sv
rtl/mmc_spi_slave.sv
rtl/config_regs.sv
rtl/tmds_encoder.sv
rtl/tmds_test.sv
rtl/board_test_top.sv
verification/board_test_tb.sv
